/* source/cpu_pkg.sv */
package cpu_pkg;

	// datapath word, also used for instruction addresses
	typedef logic [15:0] word_t;
	// general register index, eight registers
	typedef logic [2:0] reg_addr_t;
	// major opcode, instr[15:12]
	typedef logic [3:0] opcode_t;
	// data memory index, low six address bits
	typedef logic [5:0] dmem_addr_t;

	// major opcodes
	localparam opcode_t OP_ADI = 4'b0000;
	localparam opcode_t OP_ADD = 4'b0001;
	localparam opcode_t OP_NAND = 4'b0010;
	localparam opcode_t OP_LHI = 4'b0011;
	localparam opcode_t OP_LW = 4'b0100;
	localparam opcode_t OP_SW = 4'b0101;
	localparam opcode_t OP_NOP = 4'b0111;
	localparam opcode_t OP_BEQ = 4'b1000;
	localparam opcode_t OP_JAL = 4'b1001;

	// bubble word inserted into the pipeline on a flush
	localparam word_t NOP_INSTR = {OP_NOP, 12'h000};

	localparam int NUM_REGS = 8;
	localparam int DMEM_DEPTH = 64;
	localparam word_t RESET_PC = 16'h0000;

	// lsb position of each instruction field
	localparam int OP_LSB = 12;
	localparam int RA_LSB = 9;
	localparam int RB_LSB = 6;
	localparam int RC_LSB = 3;
	// lhi puts imm9 above seven zero bits
	localparam int LHI_SHIFT = 7;

	// fetch to decode
	typedef struct packed {
		logic valid;
		word_t pc;
		word_t instr;
	} fetch_out_t;

	// decode to execute, imm already selected and extended
	typedef struct packed {
		logic valid;
		opcode_t op;
		word_t pc;
		reg_addr_t dest;
		logic writes_reg;
		reg_addr_t src_a;
		reg_addr_t src_b;
		word_t data_a;
		word_t data_b;
		word_t imm;
	} id_ex_t;

	// execute to memory, result is the alu value or the memory address
	typedef struct packed {
		logic valid;
		logic writes_reg;
		logic is_load;
		logic is_store;
		reg_addr_t dest;
		word_t result;
		word_t store_data;
	} ex_mem_t;

	// register write port, also the commit port of the core
	typedef struct packed {
		logic valid;
		reg_addr_t dest;
		word_t data;
	} wb_t;

	// pc redirect request from jal or a taken beq
	typedef struct packed {
		logic valid;
		word_t target;
	} redirect_t;

endpackage

/* source/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input cpu_pkg::redirect_t ex_redirect,
	input cpu_pkg::redirect_t id_redirect,
	output cpu_pkg::word_t imem_addr,
	input cpu_pkg::word_t imem_data,
	output cpu_pkg::fetch_out_t fetch_out
);

	cpu_pkg::word_t pc;
	cpu_pkg::word_t pc_next;
	cpu_pkg::redirect_t redirect;

	// instruction memory is read combinationally at the current pc
	assign imem_addr = pc;

	// beq from execute is older than jal in decode, so it wins
	assign redirect = ex_redirect.valid ? ex_redirect : id_redirect;

	always_comb begin
		pc_next = pc + 16'd1;
		if (redirect.valid) begin
			pc_next = redirect.target;
		end else if (stall) begin
			// load-use bubble holds the pc one cycle
			pc_next = pc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= cpu_pkg::RESET_PC;
			fetch_out.valid <= 1'b0;
		end else begin
			pc <= pc_next;
			if (redirect.valid) begin
				// the word fetched this cycle is on the wrong path
				fetch_out.valid <= 1'b0;
				fetch_out.instr <= cpu_pkg::NOP_INSTR;
			end else if (!stall) begin
				fetch_out.valid <= 1'b1;
				fetch_out.pc <= pc;
				fetch_out.instr <= imem_data;
			end
		end
	end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::fetch_out_t fetch_out,
	input cpu_pkg::wb_t wb,
	input cpu_pkg::redirect_t ex_redirect,
	output cpu_pkg::id_ex_t id_ex,
	output cpu_pkg::redirect_t id_redirect,
	output logic stall
);

	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];
	cpu_pkg::opcode_t op;
	cpu_pkg::reg_addr_t ra;
	cpu_pkg::reg_addr_t rb;
	cpu_pkg::reg_addr_t rc;
	cpu_pkg::word_t imm6_ext;
	cpu_pkg::word_t imm9_ext;
	cpu_pkg::reg_addr_t dest;
	cpu_pkg::reg_addr_t src_a;
	cpu_pkg::reg_addr_t src_b;
	cpu_pkg::word_t imm;
	cpu_pkg::word_t data_a;
	cpu_pkg::word_t data_b;
	logic writes_reg;
	logic reads_a;
	logic reads_b;
	cpu_pkg::id_ex_t id_ex_next;

	// instruction fields
	assign op = fetch_out.instr[cpu_pkg::OP_LSB +: 4];
	assign ra = fetch_out.instr[cpu_pkg::RA_LSB +: 3];
	assign rb = fetch_out.instr[cpu_pkg::RB_LSB +: 3];
	assign rc = fetch_out.instr[cpu_pkg::RC_LSB +: 3];
	assign imm6_ext = {{10{fetch_out.instr[5]}}, fetch_out.instr[5:0]};
	assign imm9_ext = {{7{fetch_out.instr[8]}}, fetch_out.instr[8:0]};

	// operand a is the first alu input or the memory base,
	// operand b is the second alu input or the store data
	always_comb begin
		dest = ra;
		src_a = ra;
		src_b = rb;
		imm = imm6_ext;
		writes_reg = 1'b0;
		reads_a = 1'b0;
		reads_b = 1'b0;
		case (op)
			cpu_pkg::OP_ADD, cpu_pkg::OP_NAND: begin
				dest = rc;
				writes_reg = 1'b1;
				reads_a = 1'b1;
				reads_b = 1'b1;
			end
			cpu_pkg::OP_ADI: begin
				dest = rb;
				writes_reg = 1'b1;
				reads_a = 1'b1;
			end
			cpu_pkg::OP_LHI: begin
				writes_reg = 1'b1;
				imm = imm9_ext << cpu_pkg::LHI_SHIFT;
			end
			cpu_pkg::OP_LW: begin
				src_a = rb;
				writes_reg = 1'b1;
				reads_a = 1'b1;
			end
			cpu_pkg::OP_SW: begin
				src_a = rb;
				src_b = ra;
				reads_a = 1'b1;
				reads_b = 1'b1;
			end
			cpu_pkg::OP_BEQ: begin
				reads_a = 1'b1;
				reads_b = 1'b1;
			end
			cpu_pkg::OP_JAL: begin
				// link value pc+1 is formed in execute
				writes_reg = 1'b1;
				imm = imm9_ext;
			end
			default: begin
				// nop and unused opcodes write nothing
				writes_reg = 1'b0;
			end
		endcase
	end

	// register file, a write from wb in this cycle is seen by the read
	assign data_a = (wb.valid && wb.dest == src_a) ? wb.data : regs[src_a];
	assign data_b = (wb.valid && wb.dest == src_b) ? wb.data : regs[src_b];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// lw sitting in execute has no data yet for a dependent reader
	assign stall = fetch_out.valid && id_ex.valid && id_ex.op == cpu_pkg::OP_LW &&
		((reads_a && src_a == id_ex.dest) || (reads_b && src_b == id_ex.dest));

	// jal resolves here, a taken beq in execute overrides it
	assign id_redirect.valid = fetch_out.valid && op == cpu_pkg::OP_JAL && !ex_redirect.valid;
	assign id_redirect.target = fetch_out.pc + imm9_ext;

	always_comb begin
		id_ex_next.valid = fetch_out.valid;
		id_ex_next.op = op;
		id_ex_next.pc = fetch_out.pc;
		id_ex_next.dest = dest;
		id_ex_next.writes_reg = fetch_out.valid && writes_reg;
		id_ex_next.src_a = src_a;
		id_ex_next.src_b = src_b;
		id_ex_next.data_a = data_a;
		id_ex_next.data_b = data_b;
		id_ex_next.imm = imm;
		// bubble for load-use or for the flush behind a taken beq
		if (stall || ex_redirect.valid) begin
			id_ex_next.valid = 1'b0;
			id_ex_next.writes_reg = 1'b0;
			id_ex_next.op = cpu_pkg::OP_NOP;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.valid <= 1'b0;
			id_ex.writes_reg <= 1'b0;
		end else begin
			id_ex <= id_ex_next;
		end
	end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::id_ex_t id_ex,
	input cpu_pkg::wb_t wb,
	output cpu_pkg::ex_mem_t ex_mem,
	output cpu_pkg::redirect_t ex_redirect
);

	cpu_pkg::word_t op_a;
	cpu_pkg::word_t op_b;
	cpu_pkg::word_t result;
	cpu_pkg::ex_mem_t ex_mem_next;

	// pick the youngest producer of a source register
	function automatic cpu_pkg::word_t forward(
		input cpu_pkg::reg_addr_t src,
		input cpu_pkg::word_t reg_value,
		input cpu_pkg::ex_mem_t mem_stage,
		input cpu_pkg::wb_t wb_stage
	);
		cpu_pkg::word_t value;
		value = reg_value;
		// a load in memory only holds its address, stall covers that case
		if (mem_stage.valid && mem_stage.writes_reg && !mem_stage.is_load &&
			mem_stage.dest == src) begin
			value = mem_stage.result;
		end else if (wb_stage.valid && wb_stage.dest == src) begin
			value = wb_stage.data;
		end
		return value;
	endfunction

	assign op_a = forward(id_ex.src_a, id_ex.data_a, ex_mem, wb);
	assign op_b = forward(id_ex.src_b, id_ex.data_b, ex_mem, wb);

	// alu
	always_comb begin
		case (id_ex.op)
			cpu_pkg::OP_ADD: result = op_a + op_b;
			cpu_pkg::OP_NAND: result = ~(op_a & op_b);
			// adi value and the lw or sw address share the adder
			cpu_pkg::OP_ADI, cpu_pkg::OP_LW, cpu_pkg::OP_SW: result = op_a + id_ex.imm;
			cpu_pkg::OP_LHI: result = id_ex.imm;
			// link address for jal
			cpu_pkg::OP_JAL: result = id_ex.pc + 16'd1;
			default: result = '0;
		endcase
	end

	// beq is taken on equal operands, target is pc plus imm6
	assign ex_redirect.valid = id_ex.valid && id_ex.op == cpu_pkg::OP_BEQ && op_a == op_b;
	assign ex_redirect.target = id_ex.pc + id_ex.imm;

	always_comb begin
		ex_mem_next.valid = id_ex.valid;
		ex_mem_next.writes_reg = id_ex.valid && id_ex.writes_reg;
		ex_mem_next.is_load = id_ex.valid && id_ex.op == cpu_pkg::OP_LW;
		ex_mem_next.is_store = id_ex.valid && id_ex.op == cpu_pkg::OP_SW;
		ex_mem_next.dest = id_ex.dest;
		ex_mem_next.result = result;
		// sw data comes through operand b with forwarding applied
		ex_mem_next.store_data = op_b;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.valid <= 1'b0;
			ex_mem.writes_reg <= 1'b0;
			ex_mem.is_load <= 1'b0;
			ex_mem.is_store <= 1'b0;
		end else begin
			ex_mem <= ex_mem_next;
		end
	end

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ns

module memory_stage (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::ex_mem_t ex_mem,
	output cpu_pkg::wb_t wb
);

	cpu_pkg::word_t dmem [cpu_pkg::DMEM_DEPTH];
	cpu_pkg::dmem_addr_t addr;
	cpu_pkg::word_t load_data;

	// addresses wrap onto the 64 words
	assign addr = ex_mem.result[5:0];

	// asynchronous read so the load value is ready in the same cycle
	assign load_data = dmem[addr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (ex_mem.is_store) begin
			dmem[addr] <= ex_mem.store_data;
		end
	end

	// memory/writeback register, valid only for register writes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= ex_mem.valid && ex_mem.writes_reg;
			wb.dest <= ex_mem.dest;
			wb.data <= ex_mem.is_load ? load_data : ex_mem.result;
		end
	end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top (
	input logic clk,
	input logic rst_n,
	output cpu_pkg::word_t imem_addr,
	input cpu_pkg::word_t imem_data,
	output cpu_pkg::wb_t commit
);

	cpu_pkg::fetch_out_t fetch_out;
	cpu_pkg::id_ex_t id_ex;
	cpu_pkg::ex_mem_t ex_mem;
	cpu_pkg::redirect_t id_redirect;
	cpu_pkg::redirect_t ex_redirect;
	logic stall;

	fetch_stage fetch0 (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.ex_redirect(ex_redirect),
		.id_redirect(id_redirect),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.fetch_out(fetch_out)
	);

	// commit doubles as the register file write port
	decode_stage decode0 (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_out(fetch_out),
		.wb(commit),
		.ex_redirect(ex_redirect),
		.id_ex(id_ex),
		.id_redirect(id_redirect),
		.stall(stall)
	);

	execute_stage execute0 (
		.clk(clk),
		.rst_n(rst_n),
		.id_ex(id_ex),
		.wb(commit),
		.ex_mem(ex_mem),
		.ex_redirect(ex_redirect)
	);

	memory_stage memory0 (
		.clk(clk),
		.rst_n(rst_n),
		.ex_mem(ex_mem),
		.wb(commit)
	);

endmodule

/* bench/cpu_properties.sv */
`timescale 1ns/1ns

module cpu_properties (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input cpu_pkg::wb_t commit
);

	int fail_count = 0;

	// writeback register comes out of reset empty
	assert property (@(posedge clk) !rst_n |=> !commit.valid)
		else begin
			$error("commit.valid high in the cycle after reset");
			fail_count++;
		end

	// a load-use bubble lasts exactly one cycle
	assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
		else begin
			$error("stall high for two cycles in a row");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		commit.valid |-> !$isunknown(commit.dest))
		else begin
			$error("commit.dest unknown while commit.valid is high");
			fail_count++;
		end

endmodule

bind cpu_top cpu_properties props0 (
	.clk(clk),
	.rst_n(rst_n),
	.stall(stall),
	.commit(commit)
);

/* bench/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 2;
	localparam int PROG_DEPTH = 64;
	localparam int EXP_DEPTH = 256;
	localparam int MODEL_STEPS = 200;
	// pc has to sit past the program this long before a test counts as drained
	localparam int DRAIN_CYCLES = 8;
	localparam int NUM_RANDOM = 3;
	localparam int RANDOM_LEN = 40;
	// directed programs hold 8, 8, 9 and 6 instructions
	localparam int NUM_TESTS = 4 + NUM_RANDOM;
	localparam int TOTAL_INSTR = 31 + NUM_RANDOM * RANDOM_LEN;
	localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 30 + NUM_TESTS * RESET_CYCLES;

	logic clk;
	logic rst_n;
	cpu_pkg::word_t imem_addr;
	cpu_pkg::word_t imem_data;
	cpu_pkg::wb_t commit;

	cpu_pkg::word_t prog [PROG_DEPTH];
	int prog_len;
	// expected register writes in program order
	cpu_pkg::reg_addr_t exp_dest [EXP_DEPTH];
	cpu_pkg::word_t exp_data [EXP_DEPTH];
	int exp_count;
	int got_count;
	int test_errors;
	int tests_passed;
	int tests_failed;
	int assert_fails;

	cpu_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.commit(commit)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			clk = ~clk;
		end
	end

	// program memory model, nop beyond the loaded program
	always @(posedge clk) begin
		#2;
		if (imem_addr < prog_len) begin
			imem_data = prog[imem_addr];
		end else begin
			imem_data = cpu_pkg::NOP_INSTR;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	task automatic check_dest(input int idx, input cpu_pkg::reg_addr_t got,
		input cpu_pkg::reg_addr_t exp);
		if (got !== exp) begin
			$display("Fail commit.dest write %0d: got %h expected %h", idx, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_data(input int idx, input cpu_pkg::word_t got,
		input cpu_pkg::word_t exp);
		if (got !== exp) begin
			$display("Fail commit.data write %0d: got %h expected %h", idx, got, exp);
			test_errors++;
		end
	endtask

	// commit is registered, so look at it half a cycle later
	always @(negedge clk) begin
		if (rst_n && commit.valid) begin
			if (got_count < exp_count) begin
				check_dest(got_count, commit.dest, exp_dest[got_count]);
				check_data(got_count, commit.data, exp_data[got_count]);
			end else begin
				$display("unexpected extra register write to r%0d beyond the %0d expected",
					commit.dest, exp_count);
				test_errors++;
			end
			got_count++;
		end
	end

	// isa model, runs prog from zeroed state and lists every register write
	function automatic int run_model();
		cpu_pkg::word_t r [cpu_pkg::NUM_REGS];
		cpu_pkg::word_t mem [cpu_pkg::DMEM_DEPTH];
		cpu_pkg::word_t pc;
		cpu_pkg::word_t next_pc;
		cpu_pkg::word_t ins;
		cpu_pkg::word_t s6;
		cpu_pkg::word_t s9;
		cpu_pkg::word_t addr;
		cpu_pkg::word_t wr_data;
		cpu_pkg::reg_addr_t ra;
		cpu_pkg::reg_addr_t rb;
		cpu_pkg::reg_addr_t rc;
		cpu_pkg::reg_addr_t wr_dest;
		logic wr_en;
		int n;
		int steps;
		n = 0;
		pc = cpu_pkg::RESET_PC;
		for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
			r[i] = '0;
		end
		for (int i = 0; i < cpu_pkg::DMEM_DEPTH; i++) begin
			mem[i] = '0;
		end
		for (steps = 0; steps < MODEL_STEPS && pc < prog_len; steps++) begin
			ins = prog[pc];
			ra = ins[11:9];
			rb = ins[8:6];
			rc = ins[5:3];
			s6 = {{10{ins[5]}}, ins[5:0]};
			s9 = {{7{ins[8]}}, ins[8:0]};
			addr = r[rb] + s6;
			next_pc = pc + 16'd1;
			wr_en = 1'b0;
			wr_dest = ra;
			wr_data = '0;
			case (ins[15:12])
				cpu_pkg::OP_ADD: begin
					wr_en = 1'b1;
					wr_dest = rc;
					wr_data = r[ra] + r[rb];
				end
				cpu_pkg::OP_NAND: begin
					wr_en = 1'b1;
					wr_dest = rc;
					wr_data = ~(r[ra] & r[rb]);
				end
				cpu_pkg::OP_ADI: begin
					wr_en = 1'b1;
					wr_dest = rb;
					wr_data = r[ra] + s6;
				end
				cpu_pkg::OP_LHI: begin
					wr_en = 1'b1;
					wr_data = {ins[8:0], 7'b0000000};
				end
				cpu_pkg::OP_LW: begin
					wr_en = 1'b1;
					wr_data = mem[addr[5:0]];
				end
				cpu_pkg::OP_SW: mem[addr[5:0]] = r[ra];
				cpu_pkg::OP_BEQ: begin
					if (r[ra] == r[rb]) begin
						next_pc = pc + s6;
					end
				end
				cpu_pkg::OP_JAL: begin
					wr_en = 1'b1;
					wr_data = pc + 16'd1;
					next_pc = pc + s9;
				end
				default: wr_en = 1'b0;
			endcase
			if (wr_en) begin
				r[wr_dest] = wr_data;
				exp_dest[n] = wr_dest;
				exp_data[n] = wr_data;
				n++;
			end
			pc = next_pc;
		end
		return n;
	endfunction

	// instruction encoders
	function automatic cpu_pkg::word_t rtype(cpu_pkg::opcode_t op, int a, int b, int c);
		return {op, 3'(a), 3'(b), 3'(c), 3'b000};
	endfunction

	function automatic cpu_pkg::word_t itype(cpu_pkg::opcode_t op, int a, int b, int imm);
		return {op, 3'(a), 3'(b), 6'(imm)};
	endfunction

	function automatic cpu_pkg::word_t jtype(cpu_pkg::opcode_t op, int a, int imm);
		return {op, 3'(a), 9'(imm)};
	endfunction

	task automatic append_instr(input cpu_pkg::word_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// back to back dependences, forwarding from both later stages
	task automatic load_chain();
		prog_len = 0;
		append_instr(jtype(cpu_pkg::OP_LHI, 1, 9'h0a5));
		append_instr(itype(cpu_pkg::OP_ADI, 1, 2, 5));
		append_instr(rtype(cpu_pkg::OP_ADD, 1, 2, 3));
		append_instr(rtype(cpu_pkg::OP_NAND, 3, 2, 4));
		append_instr(itype(cpu_pkg::OP_ADI, 4, 4, -3));
		append_instr(rtype(cpu_pkg::OP_ADD, 4, 3, 1));
		append_instr(rtype(cpu_pkg::OP_NAND, 1, 1, 5));
		append_instr(rtype(cpu_pkg::OP_ADD, 5, 4, 6));
	endtask

	// store then load the same word, loaded value used right away
	task automatic load_memory();
		prog_len = 0;
		append_instr(jtype(cpu_pkg::OP_LHI, 1, 1));
		append_instr(itype(cpu_pkg::OP_ADI, 1, 1, 7));
		append_instr(itype(cpu_pkg::OP_ADI, 0, 2, 12));
		append_instr(itype(cpu_pkg::OP_SW, 1, 2, 3));
		append_instr(itype(cpu_pkg::OP_LW, 3, 2, 3));
		append_instr(rtype(cpu_pkg::OP_ADD, 3, 1, 4));
		append_instr(itype(cpu_pkg::OP_LW, 5, 0, 15));
		append_instr(rtype(cpu_pkg::OP_ADD, 5, 5, 6));
	endtask

	// taken beq over two adi, then a beq that falls through
	task automatic load_branch();
		prog_len = 0;
		append_instr(itype(cpu_pkg::OP_ADI, 0, 1, 4));
		append_instr(itype(cpu_pkg::OP_ADI, 0, 2, 4));
		append_instr(itype(cpu_pkg::OP_BEQ, 1, 2, 3));
		append_instr(itype(cpu_pkg::OP_ADI, 0, 3, 1));
		append_instr(itype(cpu_pkg::OP_ADI, 0, 4, 2));
		append_instr(itype(cpu_pkg::OP_ADI, 0, 5, 3));
		append_instr(itype(cpu_pkg::OP_BEQ, 1, 5, 2));
		append_instr(itype(cpu_pkg::OP_ADI, 0, 6, 6));
		append_instr(rtype(cpu_pkg::OP_ADD, 1, 2, 7));
	endtask

	// jal over one word, link used later, jal to the very next word
	task automatic load_jump();
		prog_len = 0;
		append_instr(itype(cpu_pkg::OP_ADI, 0, 1, 9));
		append_instr(jtype(cpu_pkg::OP_JAL, 2, 2));
		append_instr(itype(cpu_pkg::OP_ADI, 0, 3, 7));
		append_instr(rtype(cpu_pkg::OP_ADD, 2, 1, 4));
		append_instr(jtype(cpu_pkg::OP_JAL, 5, 1));
		append_instr(rtype(cpu_pkg::OP_NAND, 5, 4, 6));
	endtask

	function automatic cpu_pkg::opcode_t random_opcode();
		case ($urandom_range(5))
			0: return cpu_pkg::OP_ADD;
			1: return cpu_pkg::OP_ADI;
			2: return cpu_pkg::OP_NAND;
			3: return cpu_pkg::OP_LHI;
			4: return cpu_pkg::OP_SW;
			default: return cpu_pkg::OP_LW;
		endcase
	endfunction

	// no control flow, all fields random
	task automatic load_random();
		prog_len = 0;
		for (int i = 0; i < RANDOM_LEN; i++) begin
			append_instr({random_opcode(), 12'($urandom)});
		end
	endtask

	task automatic run_test(input string name);
		int quiet;
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		exp_count = run_model();
		got_count = 0;
		test_errors = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// done once fetch has left the program and the pipe has emptied
		quiet = 0;
		while (quiet < DRAIN_CYCLES) begin
			@(negedge clk);
			if (imem_addr >= prog_len) begin
				quiet++;
			end else begin
				quiet = 0;
			end
		end
		if (got_count < exp_count) begin
			$display("%s: only %0d of %0d expected register writes were committed",
				name, got_count, exp_count);
			test_errors++;
		end
		if (test_errors == 0) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
		$display("test %s: %0d writes expected, %0d seen, %0d errors",
			name, exp_count, got_count, test_errors);
	endtask

	initial begin
		void'($urandom(32'hec2c8ce8));
		rst_n = 1'b0;
		imem_data = cpu_pkg::NOP_INSTR;
		prog_len = 0;
		exp_count = 0;
		got_count = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		load_chain();
		run_test("alu chain");
		load_memory();
		run_test("store load use");
		load_branch();
		run_test("beq taken and not taken");
		load_jump();
		run_test("jal");
		for (int i = 0; i < NUM_RANDOM; i++) begin
			load_random();
			run_test($sformatf("random %0d", i));
		end
		assert_fails = dut0.props0.fail_count;
		$display("%0d tests passed, %0d tests failed, %0d assertion failures",
			tests_passed, tests_failed, assert_fails);
		if (tests_failed == 0 && assert_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* sources.f */
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
bench/cpu_properties.sv
bench/cpu_tb.sv
